// ==== tb/execute_golden.hex ====
// stim: {bub,ld,st,br,op[2],alu[2]} {s1[2],s2[2],tgt[2],bc[2]} imm pc ro1 ro2 {mtgt[2],wtgt[2],mld,mbub,00} mres wres
// expect: {stall,branch,flags,00000} branch_tgt {tgt_out[2],bub_out,mem_re,is_load_out,we,00} result addr store_data
10000000 00000000 00000000 00000000 00000000 00000000 00000100 00000000 00000000
00000000 00000004 00100000 00000000 00000000 00000000
// forwarding priority: execute, memory, writeback, source zero
00000000 01020500 00000000 00001000 00000100 00000023 00000100 00000000 00000000
00000000 00001004 05000000 00000123 00000123 00000023
00000000 05000600 00000000 00001004 0000dead 00000000 05050000 00005000 00006000
00000000 00001008 06000000 00000123 00000123 00000000
00000000 05000700 00000000 00001008 0000dead 00000000 05050000 00005000 00006000
00000000 0000100c 07000000 00005000 00005000 00000000
00000000 05000800 00000000 0000100c 0000dead 00000000 09050000 00005000 00006000
00000000 00001010 08000000 00006000 00006000 00000000
00000000 00000900 00000000 00001010 00000000 00000000 00000000 00005000 00006000
00000000 00001014 09000000 00000000 00000000 00000000
// load then use: stall on execute load, stall on memory load, release from writeback
01000300 01000a00 00000008 00001014 00002000 00000000 00000100 00000000 00000000
00200000 00001018 0a011000 00002008 00002008 00000000
00000000 0a000b00 00000000 00001018 00000000 00000000 00000100 00000000 00000000
10200000 0000101c 00100000 00000000 00000000 00000000
00000000 0a000b00 00000000 00001018 00000000 00000000 0a001000 00000000 00000000
10200000 0000101c 00100000 00000000 00000000 00000000
00000000 0a000b00 00000000 00001018 00000000 00000000 000a0100 00000000 00000044
00200000 0000101c 0b000000 00000044 00000044 00000000
// alu flags: sub equal, add carry, add overflow, xor
00000001 01020c00 00000000 0000101c 00000055 00000055 00000100 00000000 00000000
00000000 00001020 0c000000 00000000 00000000 00000055
00000100 01000d00 00000020 00001020 fffffff0 00000000 00000100 00000000 00000000
00200000 00001024 0d000000 00000010 00000010 00000000
00000100 01000e00 00000001 00001024 7fffffff 00000000 00000100 00000000 00000000
00100000 00001028 0e000000 80000000 80000000 00000000
00000004 01020f00 00000000 00001028 f0f00000 0ff00000 00000100 00000000 00000000
00c00000 0000102c 0f000000 ff000000 ff000000 0ff00000
// branches and jumps with the sign flag set
00010c00 00000003 00000010 00002000 00000000 00000000 00000100 00000000 00000000
01400000 00002044 00000000 00000000 00000000 00000000
00010c00 0000000c fffffffe 00002010 00000000 00000000 00000100 00000000 00000000
00400000 0000200c 00000000 00000000 00000000 00000000
00010d00 03001f00 00000000 00002020 00003000 00000000 00000100 00000000 00000000
01400000 00003000 1f000000 00002024 00003000 00000000
00010e00 03001e12 00000000 00002030 00000100 00000000 00000100 00000000 00000000
01400000 00002134 1e000000 00002034 00000100 00000000
// stores at each size and offset, then a load and a final bubble
00100300 01020000 00000000 00003000 00004000 11223344 00000100 00000000 00000000
00400000 00003004 00000f00 00004000 00004000 11223344
00100600 01020000 00000002 00003004 00004000 11223344 00000100 00000000 00000000
00400000 00003008 00000c00 00004002 00004002 33440000
00100700 01020000 00000000 00003008 00000ff4 11223344 00000100 00000000 00000000
00400000 0000300c 00000300 00000ff4 00004000 00003344
00100900 01020000 00000001 0000300c 00004000 11223344 00000100 00000000 00000000
00400000 00003010 00000200 00004001 00004001 00004400
00100a00 01020000 00000000 00003010 00000fef 11223344 00000100 00000000 00000000
00400000 00003014 00000800 00000fef 00004003 44000000
00100900 01020000 00000002 00003014 00004000 11223344 00000100 00000000 00000000
00400000 00003018 00000400 00004002 00004002 00440000
00100900 01020000 00000000 00003018 00004000 11223344 00000100 00000000 00000000
00400000 0000301c 00000100 00004000 00004000 00000044
01000600 01001000 00000002 0000301c 00004000 00000000 00000100 00000000 00000000
00400000 00003020 10011000 00004002 00004002 00000000
10000000 10000000 00000000 00003020 00000000 00000000 00000100 00000000 00000000
00400000 00003024 00100000 00000000 00000000 00000000

// ==== verilog.f ====
source/isa_pkg.sv
source/mem_pkg.sv
source/operand_forward.sv
source/alu_flags.sv
source/branch_resolve.sv
source/mem_request.sv
source/execute_stage.sv
tb/tb_execute_stage.sv

// ==== tb/tb_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage;

  localparam int clk_period = 100;
  localparam int n_vec = 27;
  localparam int vec_words = 15;
  localparam int unsigned rand_seed = 32'hea98_d56c;
  // word offsets of the expected values inside one vector
  localparam int exp_comb = 9;
  localparam int exp_branch_tgt = 10;
  localparam int exp_regs = 11;
  localparam int exp_result = 12;
  localparam int exp_addr = 13;
  localparam int exp_store = 14;

  logic clk;
  logic rst;
  logic bubble_in;
  isa_pkg::opcode_t opcode;
  isa_pkg::reg_idx_t s_1;
  isa_pkg::reg_idx_t s_2;
  isa_pkg::reg_idx_t tgt;
  isa_pkg::alu_op_t alu_op;
  logic [isa_pkg::data_w-1:0] imm;
  isa_pkg::branch_code_t branch_code;
  logic [isa_pkg::data_w-1:0] pc;
  logic is_load;
  logic is_store;
  logic is_branch;
  logic [isa_pkg::data_w-1:0] reg_out_1;
  logic [isa_pkg::data_w-1:0] reg_out_2;
  isa_pkg::reg_idx_t mem_tgt;
  logic [isa_pkg::data_w-1:0] mem_result;
  logic mem_is_load;
  logic mem_bubble;
  isa_pkg::reg_idx_t wb_tgt;
  logic [isa_pkg::data_w-1:0] wb_result;
  logic stall;
  logic branch;
  logic [isa_pkg::data_w-1:0] branch_tgt;
  isa_pkg::flag_t flags;
  logic [isa_pkg::data_w-1:0] result;
  isa_pkg::reg_idx_t tgt_out;
  logic bubble_out;
  logic [isa_pkg::data_w-1:0] addr;
  logic mem_re;
  logic [isa_pkg::data_w-1:0] store_data;
  mem_pkg::lane_mask_t we;
  logic is_load_out;

  logic [31:0] golden [0:n_vec*vec_words-1];
  int vec_idx;
  int word_errs;
  int flag_errs;
  int lane_errs;
  int index_errs;
  int bit_errs;

  execute_stage UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_word(input string name, input logic [isa_pkg::data_w-1:0] got,
                            input logic [isa_pkg::data_w-1:0] exp);
    if (got !== exp) begin
      word_errs++;
      $display("Fail %s at vector %0d: got %h, expected %h", name, vec_idx, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input isa_pkg::flag_t got,
                             input isa_pkg::flag_t exp);
    if (got !== exp) begin
      flag_errs++;
      $display("Fail %s at vector %0d: got %h, expected %h", name, vec_idx, got, exp);
    end
  endtask

  task automatic check_lanes(input string name, input mem_pkg::lane_mask_t got,
                             input mem_pkg::lane_mask_t exp);
    if (got !== exp) begin
      lane_errs++;
      $display("Fail %s at vector %0d: got %h, expected %h", name, vec_idx, got, exp);
    end
  endtask

  task automatic check_index(input string name, input isa_pkg::reg_idx_t got,
                             input isa_pkg::reg_idx_t exp);
    if (got !== exp) begin
      index_errs++;
      $display("Fail %s at vector %0d: got %h, expected %h", name, vec_idx, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("Fail %s at vector %0d: got %h, expected %h", name, vec_idx, got, exp);
    end
  endtask

  // one hex digit per flag bit, two per 5-bit field
  task automatic apply_vector(input int base);
    logic [31:0] ctl;
    logic [31:0] srcs;
    logic [31:0] prod;
    ctl = golden[base];
    srcs = golden[base + 1];
    prod = golden[base + 6];
    bubble_in = ctl[28];
    is_load = ctl[24];
    is_store = ctl[20];
    is_branch = ctl[16];
    opcode = ctl[12:8];
    alu_op = ctl[4:0];
    s_1 = srcs[28:24];
    s_2 = srcs[20:16];
    tgt = srcs[12:8];
    branch_code = srcs[4:0];
    imm = golden[base + 2];
    pc = golden[base + 3];
    reg_out_1 = golden[base + 4];
    reg_out_2 = golden[base + 5];
    mem_tgt = prod[28:24];
    wb_tgt = prod[20:16];
    mem_is_load = prod[12];
    mem_bubble = prod[8];
    mem_result = golden[base + 7];
    wb_result = golden[base + 8];
    // a bubble carries no immediate, so any value must do
    if (bubble_in) begin
      imm = $urandom;
    end
  endtask

  task automatic check_comb(input int base);
    logic [31:0] status;
    status = golden[base + exp_comb];
    check_bit("stall", stall, status[28]);
    check_bit("branch", branch, status[24]);
    check_flags("flags", flags, status[23:20]);
    check_word("branch_tgt", branch_tgt, golden[base + exp_branch_tgt]);
  endtask

  task automatic check_regs(input int base);
    logic [31:0] status;
    mem_pkg::store_word_u exp_data;
    status = golden[base + exp_regs];
    exp_data = golden[base + exp_store];
    check_index("tgt_out", tgt_out, status[28:24]);
    check_bit("bubble_out", bubble_out, status[20]);
    check_bit("mem_re", mem_re, status[16]);
    check_bit("is_load_out", is_load_out, status[12]);
    check_lanes("we", we, status[11:8]);
    check_word("result", result, golden[base + exp_result]);
    check_word("addr", addr, golden[base + exp_addr]);
    check_word("store_data", store_data, exp_data);
  endtask

  initial begin
    int unsigned seed;
    int unsigned seed_draw;
    seed = rand_seed;
    seed_draw = $urandom(seed);
    rst = 1'b1;
    bubble_in = 1'b1;
    opcode = '0;
    s_1 = '0;
    s_2 = '0;
    tgt = '0;
    alu_op = '0;
    imm = '0;
    branch_code = '0;
    pc = '0;
    is_load = 1'b0;
    is_store = 1'b0;
    is_branch = 1'b0;
    reg_out_1 = '0;
    reg_out_2 = '0;
    mem_tgt = '0;
    mem_result = '0;
    mem_is_load = 1'b0;
    mem_bubble = 1'b1;
    wb_tgt = '0;
    wb_result = '0;
    word_errs = 0;
    flag_errs = 0;
    lane_errs = 0;
    index_errs = 0;
    bit_errs = 0;
    $readmemh("tb/execute_golden.hex", golden);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (vec_idx = 0; vec_idx < n_vec; vec_idx++) begin
      @(negedge clk);
      apply_vector(vec_idx * vec_words);
      #10;
      check_comb(vec_idx * vec_words);
      // registered outputs settle just after the edge that ends the slot
      @(posedge clk);
      #10;
      check_regs(vec_idx * vec_words);
    end
    $display("errors: word %0d, flags %0d, lanes %0d, index %0d, bit %0d",
             word_errs, flag_errs, lane_errs, index_errs, bit_errs);
    if (word_errs + flag_errs + lane_errs + index_errs + bit_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog sized from the vector count plus reset and slack
  initial begin
    #((n_vec + 10) * clk_period);
    $display("timeout: golden replay did not finish in time");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        bubble_in,
  input  wire isa_pkg::opcode_t      opcode,
  input  wire isa_pkg::reg_idx_t     s_1,
  input  wire isa_pkg::reg_idx_t     s_2,
  input  wire isa_pkg::reg_idx_t     tgt,
  input  wire isa_pkg::alu_op_t      alu_op,
  input  wire [isa_pkg::data_w-1:0]  imm,
  input  wire isa_pkg::branch_code_t branch_code,
  input  wire [isa_pkg::data_w-1:0]  pc,
  input  wire                        is_load,
  input  wire                        is_store,
  input  wire                        is_branch,
  input  wire [isa_pkg::data_w-1:0]  reg_out_1,
  input  wire [isa_pkg::data_w-1:0]  reg_out_2,
  input  wire isa_pkg::reg_idx_t     mem_tgt,
  input  wire [isa_pkg::data_w-1:0]  mem_result,
  input  wire                        mem_is_load,
  input  wire                        mem_bubble,
  input  wire isa_pkg::reg_idx_t     wb_tgt,
  input  wire [isa_pkg::data_w-1:0]  wb_result,
  output logic                       stall,
  output logic                       branch,
  output logic [isa_pkg::data_w-1:0] branch_tgt,
  output isa_pkg::flag_t             flags,
  output logic [isa_pkg::data_w-1:0] result,
  output isa_pkg::reg_idx_t          tgt_out,
  output logic                       bubble_out,
  output logic [isa_pkg::data_w-1:0] addr,
  output logic                       mem_re,
  output logic [isa_pkg::data_w-1:0] store_data,
  output mem_pkg::lane_mask_t        we,
  output logic                       is_load_out
);

  logic live;
  logic use_imm;
  logic flags_we;
  logic [isa_pkg::data_w-1:0] op1;
  logic [isa_pkg::data_w-1:0] op2;
  logic [isa_pkg::data_w-1:0] rhs;
  logic [isa_pkg::data_w-1:0] alu_result;

  assign live = !bubble_in && !stall;

  // immediate ALU forms and every memory form add the immediate
  assign use_imm = (opcode == isa_pkg::op_alu_imm) ||
                   ((opcode >= isa_pkg::op_mem_w_abs) && (opcode <= isa_pkg::op_mem_b_rel));
  assign rhs = use_imm ? imm : op2;

  assign flags_we = live && ((opcode == isa_pkg::op_alu_reg) || (opcode == isa_pkg::op_alu_imm));

  operand_forward u_operand_forward (
    .bubble_in   (bubble_in),
    .s_1         (s_1),
    .s_2         (s_2),
    .reg_out_1   (reg_out_1),
    .reg_out_2   (reg_out_2),
    .ex_tgt      (tgt_out),
    .ex_result   (result),
    .ex_is_load  (is_load_out),
    .ex_bubble   (bubble_out),
    .mem_tgt     (mem_tgt),
    .mem_result  (mem_result),
    .mem_is_load (mem_is_load),
    .mem_bubble  (mem_bubble),
    .wb_tgt      (wb_tgt),
    .wb_result   (wb_result),
    .op1         (op1),
    .op2         (op2),
    .stall       (stall)
  );

  alu_flags u_alu_flags (
    .clk        (clk),
    .rst        (rst),
    .alu_op     (alu_op),
    .lhs        (op1),
    .rhs        (rhs),
    .flags_we   (flags_we),
    .alu_result (alu_result),
    .flags      (flags)
  );

  // branches see the flags from before this slot's own update
  branch_resolve u_branch_resolve (
    .opcode      (opcode),
    .branch_code (branch_code),
    .flags       (flags),
    .is_branch   (is_branch),
    .live        (live),
    .pc          (pc),
    .imm         (imm),
    .op1         (op1),
    .branch      (branch),
    .branch_tgt  (branch_tgt)
  );

  mem_request u_mem_request (
    .clk         (clk),
    .rst         (rst),
    .live        (live),
    .opcode      (opcode),
    .tgt         (tgt),
    .is_load     (is_load),
    .is_store    (is_store),
    .pc          (pc),
    .op2         (op2),
    .alu_result  (alu_result),
    .addr        (addr),
    .mem_re      (mem_re),
    .store_data  (store_data),
    .we          (we),
    .result      (result),
    .tgt_out     (tgt_out),
    .bubble_out  (bubble_out),
    .is_load_out (is_load_out)
  );

endmodule

`default_nettype wire

// ==== source/mem_request.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_request (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        live,
  input  wire isa_pkg::opcode_t      opcode,
  input  wire isa_pkg::reg_idx_t     tgt,
  input  wire                        is_load,
  input  wire                        is_store,
  input  wire [isa_pkg::data_w-1:0]  pc,
  input  wire [isa_pkg::data_w-1:0]  op2,
  input  wire [isa_pkg::data_w-1:0]  alu_result,
  output logic [isa_pkg::data_w-1:0] addr,
  output logic                       mem_re,
  output logic [isa_pkg::data_w-1:0] store_data,
  output mem_pkg::lane_mask_t        we,
  output logic [isa_pkg::data_w-1:0] result,
  output isa_pkg::reg_idx_t          tgt_out,
  output logic                       bubble_out,
  output logic                       is_load_out
);

  logic is_rel;
  logic is_jump;
  mem_pkg::mem_size_t size;
  logic [isa_pkg::data_w-1:0] eff_addr;
  mem_pkg::store_word_u store_u;
  mem_pkg::lane_mask_t lane_mask;

  assign is_rel = (opcode == isa_pkg::op_mem_w_rel) || (opcode == isa_pkg::op_mem_h_rel) ||
                  (opcode == isa_pkg::op_mem_b_rel);
  assign is_jump = (opcode == isa_pkg::op_jmp_abs) || (opcode == isa_pkg::op_jmp_rel);

  // relative forms address from the next instruction
  assign eff_addr = is_rel ? alu_result + pc + isa_pkg::pc_step : alu_result;

  always_comb begin
    case (opcode)
      isa_pkg::op_mem_h_abs, isa_pkg::op_mem_h_rel: size = mem_pkg::size_half;
      isa_pkg::op_mem_b_abs, isa_pkg::op_mem_b_rel: size = mem_pkg::size_byte;
      default:                                      size = mem_pkg::size_word;
    endcase
  end

  // narrow stores are moved onto the lanes picked by the low address bits
  always_comb begin
    store_u = '0;
    lane_mask = '0;
    case (size)
      mem_pkg::size_half: begin
        store_u.halves[eff_addr[mem_pkg::offset_w-1]] = op2[mem_pkg::half_w-1:0];
        lane_mask[eff_addr[mem_pkg::offset_w-1]*mem_pkg::half_bytes +: mem_pkg::half_bytes] = '1;
      end
      mem_pkg::size_byte: begin
        store_u.bytes[eff_addr[mem_pkg::offset_w-1:0]] = op2[mem_pkg::byte_w-1:0];
        lane_mask[eff_addr[mem_pkg::offset_w-1:0]] = 1'b1;
      end
      default: begin
        store_u = op2;
        lane_mask = '1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      tgt_out <= '0;
      bubble_out <= 1'b1;
      mem_re <= 1'b0;
      we <= '0;
      is_load_out <= 1'b0;
    end else if (live) begin
      // jumps hand the link address to writeback
      result <= is_jump ? pc + isa_pkg::pc_step : alu_result;
      tgt_out <= tgt;
      bubble_out <= 1'b0;
      mem_re <= is_load;
      we <= is_store ? lane_mask : '0;
      is_load_out <= is_load;
    end else begin
      result <= '0;
      tgt_out <= '0;
      bubble_out <= 1'b1;
      mem_re <= 1'b0;
      we <= '0;
      is_load_out <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    addr <= live ? eff_addr : '0;
    store_data <= live ? store_u : '0;
  end

  a_we_after_store: assert property (
    @(posedge clk) disable iff (rst) (we != '0) |-> $past(live && is_store))
    else $error("write lanes without a live store");

  a_re_we_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(mem_re && (we != '0)))
    else $error("read and write requested together");

endmodule

`default_nettype wire

// ==== source/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
  input  wire isa_pkg::opcode_t      opcode,
  input  wire isa_pkg::branch_code_t branch_code,
  input  wire isa_pkg::flag_t        flags,
  input  wire                        is_branch,
  input  wire                        live,
  input  wire [isa_pkg::data_w-1:0]  pc,
  input  wire [isa_pkg::data_w-1:0]  imm,
  input  wire [isa_pkg::data_w-1:0]  op1,
  output logic                       branch,
  output logic [isa_pkg::data_w-1:0] branch_tgt
);

  logic c;
  logic z;
  logic s;
  logic v;
  logic taken;

  assign c = flags[isa_pkg::flag_carry];
  assign z = flags[isa_pkg::flag_zero];
  assign s = flags[isa_pkg::flag_sign];
  assign v = flags[isa_pkg::flag_ovf];

  always_comb begin
    case (branch_code)
      isa_pkg::br_always:     taken = 1'b1;
      isa_pkg::br_zero:       taken = z;
      isa_pkg::br_not_zero:   taken = !z;
      isa_pkg::br_sign:       taken = s;
      isa_pkg::br_not_sign:   taken = !s;
      isa_pkg::br_carry:      taken = c;
      isa_pkg::br_not_carry:  taken = !c;
      isa_pkg::br_ovf:        taken = v;
      isa_pkg::br_not_ovf:    taken = !v;
      isa_pkg::br_pos:        taken = !z && !s;
      isa_pkg::br_not_pos:    taken = z || s;
      // signed compares use sign against overflow
      isa_pkg::br_greater:    taken = (s == v) && !z;
      isa_pkg::br_greater_eq: taken = (s == v);
      isa_pkg::br_less:       taken = (s != v) && !z;
      isa_pkg::br_less_eq:    taken = (s != v) || z;
      // unsigned compares use carry
      isa_pkg::br_above:      taken = !z && c;
      isa_pkg::br_above_eq:   taken = c || z;
      isa_pkg::br_below:      taken = !c && !z;
      isa_pkg::br_below_eq:   taken = !c || z;
      default:                taken = 1'b0;
    endcase
  end

  assign branch = live && is_branch && taken;

  always_comb begin
    case (opcode)
      isa_pkg::op_br_rel:  branch_tgt = pc + imm * isa_pkg::pc_step + isa_pkg::pc_step;
      isa_pkg::op_jmp_abs: branch_tgt = op1;
      isa_pkg::op_jmp_rel: branch_tgt = pc + op1 + isa_pkg::pc_step;
      default:             branch_tgt = pc + isa_pkg::pc_step;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/alu_flags.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_flags (
  input  wire                        clk,
  input  wire                        rst,
  input  wire isa_pkg::alu_op_t      alu_op,
  input  wire [isa_pkg::data_w-1:0]  lhs,
  input  wire [isa_pkg::data_w-1:0]  rhs,
  input  wire                        flags_we,
  output logic [isa_pkg::data_w-1:0] alu_result,
  output isa_pkg::flag_t             flags
);

  localparam int msb = isa_pkg::data_w - 1;

  logic [isa_pkg::data_w:0] sum_ext;
  logic [isa_pkg::data_w:0] diff_ext;
  logic [isa_pkg::shamt_w-1:0] shamt;
  isa_pkg::flag_t flags_next;

  // one extra bit holds carry out of add and borrow out of sub
  assign sum_ext = {1'b0, lhs} + {1'b0, rhs};
  assign diff_ext = {1'b0, lhs} - {1'b0, rhs};
  assign shamt = rhs[isa_pkg::shamt_w-1:0];

  always_comb begin
    alu_result = '0;
    flags_next = '0;
    case (alu_op)
      isa_pkg::alu_add: begin
        alu_result = sum_ext[msb:0];
        flags_next[isa_pkg::flag_carry] = sum_ext[isa_pkg::data_w];
        flags_next[isa_pkg::flag_ovf] = (lhs[msb] == rhs[msb]) && (sum_ext[msb] != lhs[msb]);
      end
      isa_pkg::alu_sub: begin
        alu_result = diff_ext[msb:0];
        flags_next[isa_pkg::flag_carry] = diff_ext[isa_pkg::data_w];
        flags_next[isa_pkg::flag_ovf] = (lhs[msb] != rhs[msb]) && (diff_ext[msb] != lhs[msb]);
      end
      isa_pkg::alu_and: alu_result = lhs & rhs;
      isa_pkg::alu_or:  alu_result = lhs | rhs;
      isa_pkg::alu_xor: alu_result = lhs ^ rhs;
      isa_pkg::alu_shl: alu_result = lhs << shamt;
      isa_pkg::alu_shr: alu_result = lhs >> shamt;
      isa_pkg::alu_sar: alu_result = $signed(lhs) >>> shamt;
      default:          alu_result = '0;
    endcase
    // zero and sign follow the result for every operation
    flags_next[isa_pkg::flag_zero] = (alu_result == '0);
    flags_next[isa_pkg::flag_sign] = alu_result[msb];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (flags_we) begin
      flags <= flags_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
  input  wire                        bubble_in,
  input  wire isa_pkg::reg_idx_t     s_1,
  input  wire isa_pkg::reg_idx_t     s_2,
  input  wire [isa_pkg::data_w-1:0]  reg_out_1,
  input  wire [isa_pkg::data_w-1:0]  reg_out_2,
  input  wire isa_pkg::reg_idx_t     ex_tgt,
  input  wire [isa_pkg::data_w-1:0]  ex_result,
  input  wire                        ex_is_load,
  input  wire                        ex_bubble,
  input  wire isa_pkg::reg_idx_t     mem_tgt,
  input  wire [isa_pkg::data_w-1:0]  mem_result,
  input  wire                        mem_is_load,
  input  wire                        mem_bubble,
  input  wire isa_pkg::reg_idx_t     wb_tgt,
  input  wire [isa_pkg::data_w-1:0]  wb_result,
  output logic [isa_pkg::data_w-1:0] op1,
  output logic [isa_pkg::data_w-1:0] op2,
  output logic                       stall
);

  // newest producer first, register file value last
  function automatic logic [isa_pkg::data_w-1:0] pick(
    input isa_pkg::reg_idx_t          src,
    input logic [isa_pkg::data_w-1:0] reg_val
  );
    logic [isa_pkg::data_w-1:0] val;
    val = reg_val;
    if (src != isa_pkg::reg_zero) begin
      if (!ex_bubble && (ex_tgt == src)) begin
        val = ex_result;
      end else if (mem_tgt == src) begin
        val = mem_result;
      end else if (wb_tgt == src) begin
        val = wb_result;
      end
    end
    return val;
  endfunction

  // load data is not ready before writeback, so a read of it must wait
  function automatic logic load_hit(input isa_pkg::reg_idx_t src);
    logic ex_hit;
    logic mem_hit;
    ex_hit = ex_is_load && !ex_bubble && (ex_tgt == src);
    mem_hit = mem_is_load && !mem_bubble && (mem_tgt == src);
    return (src != isa_pkg::reg_zero) && (ex_hit || mem_hit);
  endfunction

  // the producer signals are read inside the functions
  always_comb begin
    op1 = pick(s_1, reg_out_1);
    op2 = pick(s_2, reg_out_2);
    stall = !bubble_in && (load_hit(s_1) || load_hit(s_2));
  end

  // decode must never be told to hold a slot that carries no work
  always_comb begin
    assert final (!(stall && bubble_in))
      else $error("stall raised for a bubble slot");
  end

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int byte_w = 8;
  localparam int lanes_w = 4;
  localparam int half_bytes = 2;
  localparam int halves_n = lanes_w / half_bytes;
  localparam int half_w = half_bytes * byte_w;
  // address bits that pick a lane inside the word
  localparam int offset_w = $clog2(lanes_w);

  typedef logic [lanes_w-1:0] lane_mask_t;
  typedef logic [1:0] mem_size_t;

  localparam mem_size_t size_word = 2'd0;
  localparam mem_size_t size_half = 2'd1;
  localparam mem_size_t size_byte = 2'd2;

  // one bus word, addressed either per byte lane or per halfword
  typedef union packed {
    logic [lanes_w-1:0][byte_w-1:0] bytes;
    logic [halves_n-1:0][half_w-1:0] halves;
  } store_word_u;

endpackage

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int data_w = 32;
  localparam int reg_idx_w = 5;
  localparam int opcode_w = 5;
  localparam int alu_op_w = 5;
  localparam int branch_code_w = 5;
  localparam int flag_w = 4;
  localparam int shamt_w = $clog2(data_w);

  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [opcode_w-1:0] opcode_t;
  typedef logic [alu_op_w-1:0] alu_op_t;
  typedef logic [branch_code_w-1:0] branch_code_t;
  typedef logic [flag_w-1:0] flag_t;

  // register 0 reads as zero and is never a forwarding source
  localparam reg_idx_t reg_zero = '0;

  // instruction size, also the scale of relative branch offsets
  localparam logic [data_w-1:0] pc_step = 32'd4;

  localparam opcode_t op_alu_reg = 5'd0;
  localparam opcode_t op_alu_imm = 5'd1;
  localparam opcode_t op_mem_w_abs = 5'd3;
  localparam opcode_t op_mem_w_rel = 5'd4;
  localparam opcode_t op_mem_h_abs = 5'd6;
  localparam opcode_t op_mem_h_rel = 5'd7;
  localparam opcode_t op_mem_b_abs = 5'd9;
  localparam opcode_t op_mem_b_rel = 5'd10;
  localparam opcode_t op_br_rel = 5'd12;
  localparam opcode_t op_jmp_abs = 5'd13;
  localparam opcode_t op_jmp_rel = 5'd14;

  localparam alu_op_t alu_add = 5'd0;
  localparam alu_op_t alu_sub = 5'd1;
  localparam alu_op_t alu_and = 5'd2;
  localparam alu_op_t alu_or = 5'd3;
  localparam alu_op_t alu_xor = 5'd4;
  localparam alu_op_t alu_shl = 5'd5;
  localparam alu_op_t alu_shr = 5'd6;
  localparam alu_op_t alu_sar = 5'd7;

  localparam branch_code_t br_always = 5'd0;
  localparam branch_code_t br_zero = 5'd1;
  localparam branch_code_t br_not_zero = 5'd2;
  localparam branch_code_t br_sign = 5'd3;
  localparam branch_code_t br_not_sign = 5'd4;
  localparam branch_code_t br_carry = 5'd5;
  localparam branch_code_t br_not_carry = 5'd6;
  localparam branch_code_t br_ovf = 5'd7;
  localparam branch_code_t br_not_ovf = 5'd8;
  localparam branch_code_t br_pos = 5'd9;
  localparam branch_code_t br_not_pos = 5'd10;
  localparam branch_code_t br_greater = 5'd11;
  localparam branch_code_t br_greater_eq = 5'd12;
  localparam branch_code_t br_less = 5'd13;
  localparam branch_code_t br_less_eq = 5'd14;
  localparam branch_code_t br_above = 5'd15;
  localparam branch_code_t br_above_eq = 5'd16;
  localparam branch_code_t br_below = 5'd17;
  localparam branch_code_t br_below_eq = 5'd18;

  localparam int flag_carry = 0;
  localparam int flag_zero = 1;
  localparam int flag_sign = 2;
  localparam int flag_ovf = 3;

endpackage

`default_nettype wire
